//--- logic/lane_pkg.sv
// Shared widths, element types and enums of the vector lane, imported by every lane module
package lane_pkg;

  ////////////////////
  // Sizing
  ////////////////////

  localparam int unsigned DataWidth = 32;
  localparam int unsigned NrVRegs   = 32;
  localparam int unsigned MaxVl     = 8;

  typedef logic [DataWidth-1:0] elen_t;
  typedef logic [4:0]           vreg_t;
  // Vector length, 0 up to MaxVl
  typedef logic [3:0]           vlen_t;
  // Register index times MaxVl plus element index
  typedef logic [7:0]           vaddr_t;
  typedef logic [2:0]           vid_t;

  ////////////////////
  // Encodings
  ////////////////////

  typedef enum logic [2:0] {
    OP_VADD,
    OP_VSUB,
    OP_VAND,
    OP_VOR,
    OP_VXOR,
    OP_VLOAD,
    OP_VSTORE
  } lane_op_e;

  typedef enum logic [1:0] {
    SEQ_IDLE,
    SEQ_RUN,
    SEQ_RESP
  } seq_state_e;

endpackage

//--- logic/vector_regfile.sv
// Vector register file of the lane, element addressed, two registered read ports and one write port
`timescale 1ns/1ps

module vector_regfile import lane_pkg::*; #(
  parameter int unsigned MaxVlP = MaxVl
) (
  input  logic   clk_i,
  input  logic   rst_ni,
  input  logic   rd_en_i,
  input  vaddr_t rd_addr_a_i,
  input  vaddr_t rd_addr_b_i,
  input  logic   we_i,
  input  vaddr_t waddr_i,
  input  elen_t  wdata_i,
  output elen_t  rd_data_a_o,
  output elen_t  rd_data_b_o
);

  localparam int unsigned Depth = NrVRegs * MaxVlP;

  elen_t mem [Depth];

  ////////////////////
  // Write port
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (we_i) begin
      mem[waddr_i] <= wdata_i;
    end
  end

  ////////////////////
  // Read ports
  ////////////////////

  // Same-cycle write to the read address returns the old value
  // Data holds while no read is issued
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_data_a_o <= '0;
      rd_data_b_o <= '0;
    end else if (rd_en_i) begin
      rd_data_a_o <= mem[rd_addr_a_i];
      rd_data_b_o <= mem[rd_addr_b_i];
    end
  end

endmodule

//--- logic/lane_alu.sv
// Integer ALU of the lane, one register stage from operands to regfile write-back
`timescale 1ns/1ps

module lane_alu import lane_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     valid_i,
  input  logic     last_i,
  input  lane_op_e op_i,
  input  vaddr_t   waddr_i,
  input  elen_t    opa_i,
  input  elen_t    opb_i,
  output logic     wb_we_o,
  output vaddr_t   wb_addr_o,
  output elen_t    wb_data_o,
  output logic     done_o
);

  elen_t  result;
  logic   wb_we_q;
  logic   wb_last_q;
  vaddr_t wb_addr_q;
  elen_t  wb_data_q;

  // opa is vs2 and opb is vs1, so subtraction gives vs2 - vs1
  always_comb begin
    case (op_i)
      OP_VADD: result = opa_i + opb_i;
      OP_VSUB: result = opa_i - opb_i;
      OP_VAND: result = opa_i & opb_i;
      OP_VOR:  result = opa_i | opb_i;
      OP_VXOR: result = opa_i ^ opb_i;
      default: result = opa_i;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wb_we_q   <= 1'b0;
      wb_last_q <= 1'b0;
    end else begin
      wb_we_q   <= valid_i;
      wb_last_q <= valid_i & last_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      wb_addr_q <= waddr_i;
      wb_data_q <= result;
    end
  end

  assign wb_we_o   = wb_we_q;
  assign wb_addr_o = wb_addr_q;
  assign wb_data_o = wb_data_q;
  // Instruction ends with the last element's write-back
  assign done_o    = wb_we_q & wb_last_q;

endmodule

//--- logic/operand_requester.sv
// Operand requester, walks the elements of the running instruction and feeds ALU, load and store
`timescale 1ns/1ps

module operand_requester import lane_pkg::*; #(
  parameter int unsigned MaxVlP = MaxVl
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     start_i,
  input  lane_op_e op_i,
  input  vreg_t    vd_i,
  input  vreg_t    vs1_i,
  input  vreg_t    vs2_i,
  input  vlen_t    vl_i,
  output logic     done_o,
  output logic     rd_en_o,
  output vaddr_t   rd_addr_a_o,
  output vaddr_t   rd_addr_b_o,
  input  elen_t    rd_data_a_i,
  output logic     alu_valid_o,
  output logic     alu_last_o,
  output lane_op_e alu_op_o,
  output vaddr_t   alu_waddr_o,
  output logic     ld_we_o,
  output vaddr_t   ld_waddr_o,
  output elen_t    ld_wdata_o,
  input  logic     ldu_valid_i,
  input  elen_t    ldu_wdata_i,
  output logic     ldu_ready_o,
  output elen_t    stu_operand_o,
  output logic     stu_operand_valid_o,
  input  logic     stu_operand_ready_i
);

  logic     active_q;
  vlen_t    cnt_q;
  logic     is_load;
  logic     is_store;
  logic     last_elem;
  logic     alu_issue;
  logic     st_issue;
  logic     st_handoff;
  logic     advance;
  logic     rd_pend_q;
  logic     rd_pend_last_q;
  logic     stu_valid_q;
  logic     stu_last_q;
  elen_t    stu_data_q;
  logic     alu_valid_q;
  logic     alu_last_q;
  vaddr_t   alu_waddr_q;
  lane_op_e alu_op_q;

  function automatic vaddr_t elem_addr(vreg_t vreg, vlen_t idx);
    return vaddr_t'(vreg * MaxVlP + idx);
  endfunction

  assign is_load   = (op_i == OP_VLOAD);
  assign is_store  = (op_i == OP_VSTORE);
  assign last_elem = (cnt_q == vl_i - 1'b1);

  // One read in flight at most while storing
  assign alu_issue  = active_q & !is_load & !is_store;
  assign st_issue   = active_q & is_store & !rd_pend_q & (!stu_valid_q | stu_operand_ready_i);
  assign st_handoff = stu_valid_q & stu_operand_ready_i;
  assign advance    = alu_issue | st_issue | ld_we_o;

  assign ldu_ready_o = active_q & is_load;
  assign ld_we_o     = ldu_ready_o & ldu_valid_i;
  assign ld_waddr_o  = elem_addr(vd_i, cnt_q);
  assign ld_wdata_o  = ldu_wdata_i;

  // Stores read register vd through port a
  assign rd_en_o     = alu_issue | st_issue;
  assign rd_addr_a_o = is_store ? elem_addr(vd_i, cnt_q) : elem_addr(vs2_i, cnt_q);
  assign rd_addr_b_o = elem_addr(vs1_i, cnt_q);

  assign done_o = ((alu_issue | ld_we_o) & last_elem) | (st_handoff & stu_last_q);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      active_q       <= 1'b0;
      cnt_q          <= '0;
      rd_pend_q      <= 1'b0;
      rd_pend_last_q <= 1'b0;
      stu_valid_q    <= 1'b0;
      stu_last_q     <= 1'b0;
      alu_valid_q    <= 1'b0;
      alu_last_q     <= 1'b0;
    end else begin
      if (start_i) begin
        active_q <= 1'b1;
        cnt_q    <= '0;
      end else if (advance) begin
        if (last_elem) begin
          active_q <= 1'b0;
        end else begin
          cnt_q <= cnt_q + 1'b1;
        end
      end
      rd_pend_q      <= st_issue;
      rd_pend_last_q <= st_issue & last_elem;
      // Output register is always empty when the pending read lands
      if (rd_pend_q) begin
        stu_valid_q <= 1'b1;
        stu_last_q  <= rd_pend_last_q;
      end else if (st_handoff) begin
        stu_valid_q <= 1'b0;
      end
      alu_valid_q <= alu_issue;
      alu_last_q  <= alu_issue & last_elem;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_pend_q) begin
      stu_data_q <= rd_data_a_i;
    end
    if (alu_issue) begin
      alu_waddr_q <= elem_addr(vd_i, cnt_q);
      alu_op_q    <= op_i;
    end
  end

  assign stu_operand_o       = stu_data_q;
  assign stu_operand_valid_o = stu_valid_q;

  // Aligned with the regfile read data
  assign alu_valid_o = alu_valid_q;
  assign alu_last_o  = alu_last_q;
  assign alu_waddr_o = alu_waddr_q;
  assign alu_op_o    = alu_op_q;

endmodule

//--- logic/lane_sequencer.sv
// Lane sequencer, accepts one vector instruction, runs it to completion and sends the response
`timescale 1ns/1ps

module lane_sequencer import lane_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  // Request port
  input  logic     pe_req_valid_i,
  input  vid_t     pe_req_id_i,
  input  lane_op_e pe_req_op_i,
  input  vreg_t    pe_req_vd_i,
  input  vreg_t    pe_req_vs1_i,
  input  vreg_t    pe_req_vs2_i,
  input  vlen_t    pe_req_vl_i,
  output logic     pe_req_ready_o,
  // Response
  output logic     pe_resp_valid_o,
  output vid_t     pe_resp_id_o,
  // Command to the operand requester
  output logic     start_o,
  output lane_op_e op_o,
  output vreg_t    vd_o,
  output vreg_t    vs1_o,
  output vreg_t    vs2_o,
  output vlen_t    vl_o,
  // Completion events
  input  logic     req_done_i,
  input  logic     alu_done_i
);

  seq_state_e state_q;
  seq_state_e state_d;
  logic       accept;
  logic       finish;
  logic       start_q;

  // Latched instruction
  vid_t     id_q;
  lane_op_e op_q;
  vreg_t    vd_q;
  vreg_t    vs1_q;
  vreg_t    vs2_q;
  vlen_t    vl_q;

  assign pe_req_ready_o = (state_q == SEQ_IDLE);
  assign accept         = pe_req_valid_i & pe_req_ready_o;

  // Memory ops end in the requester, ALU ops end at the last write-back
  always_comb begin
    if (op_q == OP_VLOAD || op_q == OP_VSTORE) begin
      finish = req_done_i;
    end else begin
      finish = alu_done_i;
    end
  end

  ////////////////////
  // State machine
  ////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      SEQ_IDLE: begin
        if (accept) begin
          state_d = SEQ_RUN;
        end
      end
      // Zero length skips the requester
      SEQ_RUN: begin
        if (vl_q == '0 || finish) begin
          state_d = SEQ_RESP;
        end
      end
      SEQ_RESP: state_d = SEQ_IDLE;
      default:  state_d = SEQ_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= SEQ_IDLE;
      start_q <= 1'b0;
      op_q    <= OP_VADD;
      vl_q    <= '0;
    end else begin
      state_q <= state_d;
      // Start pulse lands in the first RUN cycle
      start_q <= accept && (pe_req_vl_i != '0);
      if (accept) begin
        op_q <= pe_req_op_i;
        vl_q <= pe_req_vl_i;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      id_q  <= pe_req_id_i;
      vd_q  <= pe_req_vd_i;
      vs1_q <= pe_req_vs1_i;
      vs2_q <= pe_req_vs2_i;
    end
  end

  assign start_o = start_q;
  assign op_o    = op_q;
  assign vd_o    = vd_q;
  assign vs1_o   = vs1_q;
  assign vs2_o   = vs2_q;
  assign vl_o    = vl_q;

  assign pe_resp_valid_o = (state_q == SEQ_RESP);
  assign pe_resp_id_o    = id_q;

endmodule

//--- logic/lane.sv
// Vector lane top level, connects sequencer, operand requester, register file and ALU
`timescale 1ns/1ps

module lane import lane_pkg::*; #(
  parameter int unsigned MaxVlP = MaxVl
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  // Request port
  input  logic     pe_req_valid_i,
  input  vid_t     pe_req_id_i,
  input  lane_op_e pe_req_op_i,
  input  vreg_t    pe_req_vd_i,
  input  vreg_t    pe_req_vs1_i,
  input  vreg_t    pe_req_vs2_i,
  input  vlen_t    pe_req_vl_i,
  output logic     pe_req_ready_o,
  // Completion response
  output logic     pe_resp_valid_o,
  output vid_t     pe_resp_id_o,
  // Load port
  input  logic     ldu_valid_i,
  input  elen_t    ldu_wdata_i,
  output logic     ldu_ready_o,
  // Store port
  output elen_t    stu_operand_o,
  output logic     stu_operand_valid_o,
  input  logic     stu_operand_ready_i
);

  // Sequencer command
  logic     start;
  lane_op_e seq_op;
  vreg_t    seq_vd;
  vreg_t    seq_vs1;
  vreg_t    seq_vs2;
  vlen_t    seq_vl;
  logic     req_done;
  logic     alu_done;
  // Regfile reads
  logic     rd_en;
  vaddr_t   rd_addr_a;
  vaddr_t   rd_addr_b;
  elen_t    rd_data_a;
  elen_t    rd_data_b;
  // Requester to ALU
  logic     alu_valid;
  logic     alu_last;
  lane_op_e alu_op;
  vaddr_t   alu_waddr;
  // Write sources
  logic     ld_we;
  vaddr_t   ld_waddr;
  elen_t    ld_wdata;
  logic     wb_we;
  vaddr_t   wb_addr;
  elen_t    wb_data;
  logic     vrf_we;
  vaddr_t   vrf_waddr;
  elen_t    vrf_wdata;

  lane_sequencer i_lane_sequencer (
    .clk_i          (clk_i          ),
    .rst_ni         (rst_ni         ),
    .pe_req_valid_i (pe_req_valid_i ),
    .pe_req_id_i    (pe_req_id_i    ),
    .pe_req_op_i    (pe_req_op_i    ),
    .pe_req_vd_i    (pe_req_vd_i    ),
    .pe_req_vs1_i   (pe_req_vs1_i   ),
    .pe_req_vs2_i   (pe_req_vs2_i   ),
    .pe_req_vl_i    (pe_req_vl_i    ),
    .pe_req_ready_o (pe_req_ready_o ),
    .pe_resp_valid_o(pe_resp_valid_o),
    .pe_resp_id_o   (pe_resp_id_o   ),
    .start_o        (start          ),
    .op_o           (seq_op         ),
    .vd_o           (seq_vd         ),
    .vs1_o          (seq_vs1        ),
    .vs2_o          (seq_vs2        ),
    .vl_o           (seq_vl         ),
    .req_done_i     (req_done       ),
    .alu_done_i     (alu_done       )
  );

  operand_requester #(
    .MaxVlP(MaxVlP)
  ) i_operand_requester (
    .clk_i              (clk_i              ),
    .rst_ni             (rst_ni             ),
    .start_i            (start              ),
    .op_i               (seq_op             ),
    .vd_i               (seq_vd             ),
    .vs1_i              (seq_vs1            ),
    .vs2_i              (seq_vs2            ),
    .vl_i               (seq_vl             ),
    .done_o             (req_done           ),
    .rd_en_o            (rd_en              ),
    .rd_addr_a_o        (rd_addr_a          ),
    .rd_addr_b_o        (rd_addr_b          ),
    .rd_data_a_i        (rd_data_a          ),
    .alu_valid_o        (alu_valid          ),
    .alu_last_o         (alu_last           ),
    .alu_op_o           (alu_op             ),
    .alu_waddr_o        (alu_waddr          ),
    .ld_we_o            (ld_we              ),
    .ld_waddr_o         (ld_waddr           ),
    .ld_wdata_o         (ld_wdata           ),
    .ldu_valid_i        (ldu_valid_i        ),
    .ldu_wdata_i        (ldu_wdata_i        ),
    .ldu_ready_o        (ldu_ready_o        ),
    .stu_operand_o      (stu_operand_o      ),
    .stu_operand_valid_o(stu_operand_valid_o),
    .stu_operand_ready_i(stu_operand_ready_i)
  );

  // Only one instruction runs at a time, so its opcode picks the write source
  assign vrf_we    = (seq_op == OP_VLOAD) ? ld_we    : wb_we;
  assign vrf_waddr = (seq_op == OP_VLOAD) ? ld_waddr : wb_addr;
  assign vrf_wdata = (seq_op == OP_VLOAD) ? ld_wdata : wb_data;

  vector_regfile #(
    .MaxVlP(MaxVlP)
  ) i_vrf (
    .clk_i      (clk_i    ),
    .rst_ni     (rst_ni   ),
    .rd_en_i    (rd_en    ),
    .rd_addr_a_i(rd_addr_a),
    .rd_addr_b_i(rd_addr_b),
    .we_i       (vrf_we   ),
    .waddr_i    (vrf_waddr),
    .wdata_i    (vrf_wdata),
    .rd_data_a_o(rd_data_a),
    .rd_data_b_o(rd_data_b)
  );

  // Port a carries vs2, port b carries vs1
  lane_alu i_lane_alu (
    .clk_i    (clk_i    ),
    .rst_ni   (rst_ni   ),
    .valid_i  (alu_valid),
    .last_i   (alu_last ),
    .op_i     (alu_op   ),
    .waddr_i  (alu_waddr),
    .opa_i    (rd_data_a),
    .opb_i    (rd_data_b),
    .wb_we_o  (wb_we    ),
    .wb_addr_o(wb_addr  ),
    .wb_data_o(wb_data  ),
    .done_o   (alu_done )
  );

endmodule

//--- verif/lane_assert.sv
// Handshake and reset assertions of the vector lane, bound into every lane instance
`timescale 1ns/1ps

module lane_assert import lane_pkg::*; (
  input logic  clk_i,
  input logic  rst_ni,
  input logic  resp_valid_i,
  input logic  stu_valid_i,
  input logic  stu_ready_i,
  input elen_t stu_data_i
);

  // Quiet outputs while in reset
  a_reset_quiet: assert property (@(posedge clk_i)
    !rst_ni |-> (!resp_valid_i && !stu_valid_i))
    else $error("response or store valid high during reset");

  // Stalled store beat keeps valid and data
  a_store_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (stu_valid_i && !stu_ready_i) |=> (stu_valid_i && $stable(stu_data_i)))
    else $error("store operand changed while stalled");

  a_resp_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    resp_valid_i |=> !resp_valid_i)
    else $error("response valid held longer than one cycle");

endmodule

bind lane lane_assert i_lane_assert (
  .clk_i       (clk_i              ),
  .rst_ni      (rst_ni             ),
  .resp_valid_i(pe_resp_valid_o    ),
  .stu_valid_i (stu_operand_valid_o),
  .stu_ready_i (stu_operand_ready_i),
  .stu_data_i  (stu_operand_o      )
);

//--- verif/lane_tb.sv
// Simulation top that drives random vector instructions into the lane and checks them against a model
`timescale 1ns/1ps

module lane_tb import lane_pkg::*; ();

  localparam int Timeout = 200;

  logic clk, rst_n;
  logic req_valid, req_ready, resp_valid;
  vid_t req_id, resp_id, next_id;
  lane_op_e req_op;
  vreg_t req_vd, req_vs1, req_vs2;
  vlen_t req_vl;
  logic ldu_valid, ldu_ready, stu_valid, stu_ready;
  elen_t ldu_wdata, stu_data;

  int seed, errors, checks, tests, req_count, resp_count;
  vid_t exp_ids[$];
  // Expected register file contents
  elen_t model [NrVRegs*MaxVl];
  event timed_out;

  lane #(.MaxVlP(MaxVl)) uut (
    .clk_i(clk), .rst_ni(rst_n),
    .pe_req_valid_i(req_valid), .pe_req_id_i(req_id), .pe_req_op_i(req_op),
    .pe_req_vd_i(req_vd), .pe_req_vs1_i(req_vs1), .pe_req_vs2_i(req_vs2),
    .pe_req_vl_i(req_vl), .pe_req_ready_o(req_ready),
    .pe_resp_valid_o(resp_valid), .pe_resp_id_o(resp_id),
    .ldu_valid_i(ldu_valid), .ldu_wdata_i(ldu_wdata), .ldu_ready_o(ldu_ready),
    .stu_operand_o(stu_data), .stu_operand_valid_o(stu_valid),
    .stu_operand_ready_i(stu_ready)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Any timeout ends the run here
  initial begin
    @(timed_out);
    $display("FAIL: see errors above");
    $finish;
  end

  task automatic check_elem(string name, elen_t got, elen_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_id(string name, vid_t got, vid_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_flag(string name, logic got, logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic abort_run(string what);
    errors++;
    $display("ERROR: timed out waiting for %s", what);
    -> timed_out;
    // The stalled caller never resumes
    forever @(posedge clk);
  endtask

  function automatic vaddr_t model_addr(vreg_t r, int i);
    return vaddr_t'(int'(r) * int'(MaxVl) + i);
  endfunction

  // Element rule vs2 op vs1 with 32-bit wraparound
  function automatic elen_t expected_result(lane_op_e op, elen_t vs2, elen_t vs1);
    case (op)
      OP_VADD: return vs2 + vs1;
      OP_VSUB: return vs2 - vs1;
      OP_VAND: return vs2 & vs1;
      OP_VOR:  return vs2 | vs1;
      default: return vs2 ^ vs1;
    endcase
  endfunction

  function automatic vreg_t rand_vreg();
    return vreg_t'($random(seed));
  endfunction

  // 1 up to MaxVl
  function automatic vlen_t rand_vl();
    return vlen_t'(1 + ($unsigned($random(seed)) % MaxVl));
  endfunction

  task automatic issue_req(lane_op_e op, vreg_t vd, vreg_t vs1, vreg_t vs2, vlen_t vl);
    int guard;
    guard = 0;
    @(posedge clk);
    req_valid <= 1'b1;
    req_id    <= next_id;
    req_op    <= op;
    req_vd    <= vd;
    req_vs1   <= vs1;
    req_vs2   <= vs2;
    req_vl    <= vl;
    @(negedge clk);
    while (!req_ready && guard < Timeout) begin
      @(negedge clk);
      guard++;
    end
    if (!req_ready) begin
      abort_run("pe_req_ready_o");
    end
    exp_ids.push_back(next_id);
    req_count++;
    @(posedge clk);
    req_valid <= 1'b0;
    next_id++;
  endtask

  task automatic wait_resp();
    int guard;
    guard = 0;
    while (exp_ids.size() != 0 && guard < Timeout) begin
      @(posedge clk);
      guard++;
    end
    if (exp_ids.size() != 0) begin
      abort_run("pe_resp_valid_o");
    end
  endtask

  // Beats stay on offer until the response, so an extra one would be taken and counted
  task automatic load_vreg(vreg_t vd, vlen_t vl);
    int n;
    int guard;
    logic done;
    n = 0;
    guard = 0;
    done = 1'b0;
    issue_req(OP_VLOAD, vd, '0, '0, vl);
    while (!done && guard < Timeout) begin
      @(posedge clk);
      ldu_valid <= (($random(seed) & 3) != 0);
      ldu_wdata <= elen_t'($random(seed));
      @(negedge clk);
      if (ldu_valid && ldu_ready) begin
        if (n < int'(vl)) begin
          model[model_addr(vd, n)] = ldu_wdata;
        end
        n++;
      end
      done = resp_valid;
      guard++;
    end
    if (!done) begin
      abort_run("pe_resp_valid_o");
    end
    check_flag("ldu_ready_o", ldu_ready, 1'b0);
    if (n != int'(vl)) begin
      errors++;
      $display("ERROR: load of v%0d took %0d beats instead of %0d", vd, n, vl);
    end
    @(posedge clk);
    ldu_valid <= 1'b0;
  endtask

  // Every stalled cycle also compares the held beat
  task automatic store_vreg(vreg_t vd, vlen_t vl, bit stall);
    int n;
    int guard;
    n = 0;
    guard = 0;
    issue_req(OP_VSTORE, vd, '0, '0, vl);
    while (n < int'(vl) && guard < Timeout) begin
      @(posedge clk);
      stu_ready <= stall ? (($random(seed) & 1) != 0) : 1'b1;
      @(negedge clk);
      if (stu_valid) begin
        check_elem("stu_operand_o", stu_data, model[model_addr(vd, n)]);
        if (stu_ready) begin
          n++;
        end
      end
      guard++;
    end
    if (n < int'(vl)) begin
      abort_run("stu_operand_valid_o");
    end
    @(posedge clk);
    stu_ready <= 1'b0;
    wait_resp();
    @(negedge clk);
    check_flag("stu_operand_valid_o", stu_valid, 1'b0);
  endtask

  task automatic exec_alu(lane_op_e op, vreg_t vd, vreg_t vs1, vreg_t vs2, vlen_t vl);
    issue_req(op, vd, vs1, vs2, vl);
    for (int i = 0; i < int'(vl); i++) begin
      model[model_addr(vd, i)] = expected_result(op, model[model_addr(vs2, i)],
                                                 model[model_addr(vs1, i)]);
    end
    wait_resp();
  endtask

  task automatic end_test(string name, int err_before);
    tests++;
    $display("%s: %s, %0d errors", name, (errors == err_before) ? "ok" : "failed",
             errors - err_before);
  endtask

  ////////////////////
  // Response monitor
  ////////////////////

  always @(negedge clk) begin
    if (rst_n && resp_valid) begin
      resp_count++;
      if (exp_ids.size() == 0) begin
        errors++;
        $display("ERROR: response id %h arrived with no request outstanding", resp_id);
      end else begin
        check_id("pe_resp_id_o", resp_id, exp_ids.pop_front());
      end
    end
  end

  initial begin
    vreg_t vd;
    vreg_t vs1;
    lane_op_e op;
    int err_before;
    seed = 32'h872b_27a4;
    {errors, checks, tests, req_count, resp_count} = '0;
    next_id = '0;
    rst_n = 1'b0;
    req_valid = 1'b0;
    req_id = '0;
    req_op = OP_VADD;
    {req_vd, req_vs1, req_vs2, req_vl} = '0;
    ldu_valid = 1'b0;
    ldu_wdata = '0;
    stu_ready = 1'b0;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;

    err_before = errors;
    @(negedge clk);
    check_flag("pe_req_ready_o", req_ready, 1'b1);
    check_flag("pe_resp_valid_o", resp_valid, 1'b0);
    check_flag("stu_operand_valid_o", stu_valid, 1'b0);
    check_flag("ldu_ready_o", ldu_ready, 1'b0);
    end_test("reset_state", err_before);

    // Full-length loads give every register a known value
    err_before = errors;
    for (int r = 0; r < NrVRegs; r++) begin
      load_vreg(vreg_t'(r), vlen_t'(MaxVl));
    end
    repeat (16) store_vreg(rand_vreg(), rand_vl(), 1'b0);
    end_test("load_store", err_before);

    err_before = errors;
    repeat (40) begin
      op  = lane_op_e'(3'($unsigned($random(seed)) % 5));
      vd  = rand_vreg();
      vs1 = rand_vreg();
      if (($random(seed) & 3) == 0) begin
        vd = vs1;
      end
      exec_alu(op, vd, vs1, rand_vreg(), rand_vl());
      store_vreg(vd, vlen_t'(MaxVl), 1'b0);
    end
    end_test("alu_ops", err_before);

    // Partial loads leave the upper elements alone
    err_before = errors;
    repeat (20) begin
      vd = rand_vreg();
      load_vreg(vd, rand_vl());
      store_vreg(vd, vlen_t'(MaxVl), 1'b1);
    end
    end_test("store_backpressure", err_before);

    err_before = errors;
    vd = rand_vreg();
    load_vreg(vd, '0);
    exec_alu(OP_VXOR, vd, rand_vreg(), rand_vreg(), '0);
    store_vreg(vd, '0, 1'b0);
    store_vreg(vd, vlen_t'(MaxVl), 1'b1);
    vd = rand_vreg();
    exec_alu(OP_VSUB, vd, rand_vreg(), rand_vreg(), vlen_t'(MaxVl));
    store_vreg(vd, vlen_t'(MaxVl), 1'b1);
    end_test("vl_edges", err_before);

    err_before = errors;
    repeat (4) @(negedge clk);
    if (resp_count != req_count || exp_ids.size() != 0) begin
      errors++;
      $display("ERROR: %0d responses for %0d accepted requests", resp_count, req_count);
    end
    end_test("responses", err_before);

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

//--- lane.f
logic/lane_pkg.sv
logic/vector_regfile.sv
logic/lane_alu.sv
logic/operand_requester.sv
logic/lane_sequencer.sv
logic/lane.sv
verif/lane_assert.sv
verif/lane_tb.sv

//--- Makefile
# Verilator simulation of the vector lane

VERILATOR ?= verilator
TOP       ?= lane_tb
FILELIST  ?= lane.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

# Fails unless the run prints the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q '^PASS: all tests$$'

clean:
	rm -rf $(OBJ_DIR)
